// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_l2_write_path
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
rtl/l2_write_pkg.sv
rtl/write_buffer.sv
rtl/write_arbiter.sv
rtl/l2_write_path.sv
testbench/tb_clock_gen.sv
testbench/l2_write_path_properties.sv
testbench/tb_l2_write_path.sv

// ==== rtl/l2_write_path.sv ====
`timescale 1ns/1ps

module l2_write_path
    import l2_write_pkg::*;
#(
    parameter int depth = 2
) (
    input  logic                 clk,
    input  logic                 rstn,

    // Cache write requests.
    input  logic [31:0]          addr,
    input  logic [line_bits-1:0] line_data,
    input  logic                 req,
    input  logic                 dma_sign,
    input  logic [3:0]           dma_wstrb,
    output logic                 addr_ok,

    // Memory write port.
    output logic [31:0]          mem_waddr,
    output logic [word_bits-1:0] mem_wdata,
    output logic [3:0]           mem_wstrb,
    output logic [len_width-1:0] mem_len,
    output logic                 mem_wvalid,
    output logic                 mem_wlast,
    output logic                 mem_bready,
    input  logic                 mem_waddr_ok,
    input  logic                 mem_wready,
    input  logic                 mem_bvalid
);

    logic [31:0]          buf_addr;
    logic [line_bits-1:0] buf_data;
    logic                 buf_req;
    logic                 buf_addr_ok;
    logic [31:0]          buf_waddr;
    logic [word_bits-1:0] buf_wdata;
    logic                 buf_wvalid;
    logic                 buf_wlast;
    logic                 buf_bready;
    logic                 buf_waddr_ok;
    logic                 buf_wready;
    logic                 buf_bvalid;
    logic                 wrt_lock;

    write_arbiter i_arbiter (
        .clk, .rstn,
        .addr, .line_data, .req, .dma_sign, .dma_wstrb, .addr_ok,
        .buf_addr, .buf_data, .buf_req, .buf_addr_ok,
        .buf_waddr, .buf_wdata, .buf_wvalid, .buf_wlast, .buf_bready,
        .buf_waddr_ok, .buf_wready, .buf_bvalid, .wrt_lock,
        .mem_waddr, .mem_wdata, .mem_wstrb, .mem_len,
        .mem_wvalid, .mem_wlast, .mem_bready,
        .mem_waddr_ok, .mem_wready, .mem_bvalid,
        .dma_lock ()                          // No read path here.
    );

    write_buffer #(
        .depth (depth)
    ) i_buffer (
        .clk, .rstn,
        .buf_addr, .buf_data, .buf_req, .buf_addr_ok,
        .buf_waddr, .buf_wdata, .buf_wvalid, .buf_waddr_ok,
        .buf_wready, .buf_wlast, .buf_bvalid, .buf_bready,
        .wrt_lock
    );

endmodule

// ==== rtl/l2_write_pkg.sv ====
package l2_write_pkg;

    // Line geometry.
    localparam int word_bits    = 32;
    localparam int offset_width = 2;                     // log2 of words per line.
    localparam int line_words   = 1 << offset_width;
    localparam int line_bits    = line_words * word_bits;

    // Burst encoding on the memory port.
    localparam int len_width = 8;
    localparam logic [len_width-1:0] burst_len_line   = len_width'(line_words - 1);
    localparam logic [len_width-1:0] burst_len_single = '0;
    localparam logic [3:0]           strb_all         = 4'hF;

    // Same 32-bit address, seen either raw or split into line, word and byte.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31-offset_width-2:0] line;
            logic [offset_width-1:0]    word;
            logic [1:0]                 byte_sel;
        } fld;
    } l2_addr_t;

endpackage

// ==== rtl/write_arbiter.sv ====
`timescale 1ns/1ps

module write_arbiter
    import l2_write_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,

    // Cache side.
    input  logic [31:0]          addr,
    input  logic [line_bits-1:0] line_data,
    input  logic                 req,
    input  logic                 dma_sign,
    input  logic [3:0]           dma_wstrb,
    output logic                 addr_ok,

    // Buffer fill.
    output logic [31:0]          buf_addr,
    output logic [line_bits-1:0] buf_data,
    output logic                 buf_req,
    input  logic                 buf_addr_ok,

    // Buffer drain.
    input  logic [31:0]          buf_waddr,
    input  logic [word_bits-1:0] buf_wdata,
    input  logic                 buf_wvalid,
    input  logic                 buf_wlast,
    input  logic                 buf_bready,
    output logic                 buf_waddr_ok,
    output logic                 buf_wready,
    output logic                 buf_bvalid,
    input  logic                 wrt_lock,

    // Memory port.
    output logic [31:0]          mem_waddr,
    output logic [word_bits-1:0] mem_wdata,
    output logic [3:0]           mem_wstrb,
    output logic [len_width-1:0] mem_len,
    output logic                 mem_wvalid,
    output logic                 mem_wlast,
    output logic                 mem_bready,
    input  logic                 mem_waddr_ok,
    input  logic                 mem_wready,
    input  logic                 mem_bvalid,

    output logic                 dma_lock
);

    localparam logic [2:0] IDLE   = 3'd0;
    localparam logic [2:0] WRT_W  = 3'd1;
    localparam logic [2:0] DMA_AW = 3'd2;
    localparam logic [2:0] DMA_W  = 3'd3;
    localparam logic [2:0] DMA_R  = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       in_dma;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req && !dma_sign) begin
                    state_nxt = WRT_W;
                end else if (req && !wrt_lock) begin
                    state_nxt = DMA_AW;     // Uncached waits for an empty buffer.
                end
            end
            WRT_W:   if (buf_addr_ok) state_nxt = IDLE;
            DMA_AW:  if (mem_waddr_ok) state_nxt = DMA_W;
            DMA_W:   if (mem_wready) state_nxt = DMA_R;
            DMA_R:   if (mem_bvalid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign in_dma   = (state == DMA_AW) || (state == DMA_W) || (state == DMA_R);
    assign dma_lock = in_dma;

    // Fill path is only open in WRT_W.
    assign buf_addr = addr;
    assign buf_data = line_data;
    assign buf_req  = (state == WRT_W) & req;

    always_comb begin
        addr_ok = 1'b0;
        if (state == WRT_W) begin
            addr_ok = buf_addr_ok;
        end else if (state == DMA_R) begin
            addr_ok = mem_bvalid;             // Done with the write response.
        end
    end

    always_comb begin
        // Buffer owns the port outside the DMA states.
        mem_waddr    = buf_waddr;
        mem_wdata    = buf_wdata;
        mem_wstrb    = strb_all;
        mem_len      = burst_len_line;
        mem_wvalid   = buf_wvalid;
        mem_wlast    = buf_wlast;
        mem_bready   = buf_bready;
        buf_waddr_ok = mem_waddr_ok;
        buf_wready   = mem_wready;
        buf_bvalid   = mem_bvalid;
        if (in_dma) begin
            mem_waddr    = addr;
            mem_wdata    = line_data[word_bits-1:0];
            mem_wstrb    = dma_wstrb;
            mem_len      = burst_len_single;
            mem_wvalid   = (state != DMA_R);
            mem_wlast    = (state == DMA_W);
            mem_bready   = (state == DMA_R);
            buf_waddr_ok = 1'b0;
            buf_wready   = 1'b0;
            buf_bvalid   = 1'b0;
        end
    end

endmodule

// ==== rtl/write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer
    import l2_write_pkg::*;
#(
    parameter int depth = 2
) (
    input  logic                 clk,
    input  logic                 rstn,

    // Fill side from the arbiter.
    input  logic [31:0]          buf_addr,
    input  logic [line_bits-1:0] buf_data,
    input  logic                 buf_req,
    output logic                 buf_addr_ok,

    // Drain side toward the memory port.
    output logic [31:0]          buf_waddr,
    output logic [word_bits-1:0] buf_wdata,
    output logic                 buf_wvalid,
    input  logic                 buf_waddr_ok,
    input  logic                 buf_wready,
    output logic                 buf_wlast,
    input  logic                 buf_bvalid,
    output logic                 buf_bready,

    output logic                 wrt_lock
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [1:0] s_addr = 2'd0;
    localparam logic [1:0] s_data = 2'd1;
    localparam logic [1:0] s_resp = 2'd2;

    logic [31:0]             addr_mem [depth];
    logic [line_bits-1:0]    data_mem [depth];

    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic [cnt_w-1:0]        count;
    logic [1:0]              state;
    logic [1:0]              state_nxt;
    logic [offset_width-1:0] beat;
    logic                    full;
    logic                    not_empty;
    logic                    push;
    logic                    pop;
    l2_addr_t                beat_addr;

    assign full      = (count == cnt_w'(depth));
    assign not_empty = (count != '0);

    assign buf_addr_ok = buf_req & ~full;
    assign push        = buf_req & ~full;
    assign pop         = (state == s_resp) & buf_bvalid;   // Entry leaves after its response.

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= buf_addr;
            data_mem[wr_ptr] <= buf_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            state  <= s_addr;
            beat   <= '0;
        end else begin
            state <= state_nxt;
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Wraps back to zero after the last beat.
            if (state == s_data && buf_wready) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_addr: begin
                if (not_empty && buf_waddr_ok) begin
                    state_nxt = s_data;
                end
            end
            s_data: begin
                if (buf_wready && buf_wlast) begin
                    state_nxt = s_resp;
                end
            end
            s_resp: begin
                if (buf_bvalid) begin
                    state_nxt = s_addr;
                end
            end
            default: state_nxt = s_addr;
        endcase
    end

    // Beat address is the stored line with the word field replaced.
    always_comb begin
        beat_addr              = addr_mem[rd_ptr];
        beat_addr.fld.word     = beat;
        beat_addr.fld.byte_sel = '0;
    end

    assign buf_waddr  = beat_addr.raw;
    assign buf_wdata  = data_mem[rd_ptr][beat*word_bits +: word_bits];
    assign buf_wvalid = (state == s_addr) ? not_empty : (state == s_data);
    assign buf_wlast  = (state == s_data) && (beat == offset_width'(line_words - 1));
    assign buf_bready = (state == s_resp);

    // Held while anything is queued or a burst is still open.
    assign wrt_lock = not_empty || (state != s_addr);

endmodule

// ==== testbench/l2_write_path_properties.sv ====
`timescale 1ns/1ps

module l2_write_path_properties (
    input logic        clk,
    input logic        rstn,
    input logic        req,
    input logic        addr_ok,
    input logic [31:0] mem_waddr,
    input logic        mem_wvalid,
    input logic        mem_wlast,
    input logic        mem_waddr_ok,
    input logic        mem_bready,
    input logic        mem_bvalid
);

    logic addr_wait;    // High between a response and the next address handshake.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_wait <= 1'b1;
        end else if (mem_wvalid && mem_waddr_ok && addr_wait) begin
            addr_wait <= 1'b0;
        end else if (mem_bvalid && mem_bready) begin
            addr_wait <= 1'b1;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        addr_wait && mem_wvalid && !mem_waddr_ok |=> mem_wvalid && $stable(mem_waddr))
        else $error("address phase changed before mem_waddr_ok");

    a_wlast_valid: assert property (@(posedge clk) disable iff (!rstn)
        mem_wlast |-> mem_wvalid)
        else $error("mem_wlast without mem_wvalid");

    a_ok_with_req: assert property (@(posedge clk) disable iff (!rstn)
        addr_ok |-> req)
        else $error("addr_ok without req");

endmodule

bind l2_write_path l2_write_path_properties i_props (
    .clk          (clk),
    .rstn         (rstn),
    .req          (req),
    .addr_ok      (addr_ok),
    .mem_waddr    (mem_waddr),
    .mem_wvalid   (mem_wvalid),
    .mem_wlast    (mem_wlast),
    .mem_waddr_ok (mem_waddr_ok),
    .mem_bready   (mem_bready),
    .mem_bvalid   (mem_bvalid)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns   = 40.0,
    parameter int  reset_cycles = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;                   // Released on an edge.
    end

endmodule

// ==== testbench/tb_l2_write_path.sv ====
`timescale 1ns/1ps

module tb_l2_write_path
    import l2_write_pkg::*;
;
    localparam int depth      = 2;
    localparam int total_reqs = 8 + 8 + 20 + 12 + 200;

    logic                 clk, rstn;
    logic [31:0]          addr;
    logic [line_bits-1:0] line_data;
    logic                 req, dma_sign, addr_ok;
    logic [3:0]           dma_wstrb;
    logic [31:0]          mem_waddr;
    logic [word_bits-1:0] mem_wdata;
    logic [3:0]           mem_wstrb;
    logic [len_width-1:0] mem_len;
    logic                 mem_wvalid, mem_wlast, mem_bready;
    logic                 mem_waddr_ok, mem_wready, mem_bvalid;

    int unsigned rand_state = 71765;
    int n_checks, n_errors, n_tests, accepted, completed;
    int aok_stall, wr_stall, b_stall;        // Stall odds in percent.

    // Scoreboard, in acceptance order.
    l2_addr_t             exp_addr [$];
    logic [len_width-1:0] exp_len [$];
    logic [3:0]           exp_strb [$];
    logic [line_bits-1:0] exp_data [$];

    // Memory model state.
    int                   ph, beat_idx;
    l2_addr_t             act_addr;
    l2_addr_t             beat_exp;
    logic [len_width-1:0] act_len;
    logic [3:0]           act_strb;
    logic [line_bits-1:0] act_data;
    logic                 nxt_aok, nxt_wr, nxt_bv;

    tb_clock_gen i_clk (.clk, .rstn);

    l2_write_path #(.depth(depth)) i_dut (.*);

    function automatic int unsigned next_rand();
        int unsigned hi;
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        hi         = rand_state >> 16;
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return (hi << 16) | (rand_state >> 16);
    endfunction

    function automatic logic roll(int stall_pct);
        return (next_rand() % 100) >= stall_pct;
    endfunction

    task automatic check_addr(l2_addr_t got, l2_addr_t exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s address %h, expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_word(logic [word_bits-1:0] got, logic [word_bits-1:0] exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(logic [3:0] got, logic [3:0] exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s strobe %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(logic [len_width-1:0] got, logic [len_width-1:0] exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s len %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("Fail %0t: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Expected transaction from the request seen with addr_ok.
    task automatic record_accept();
        l2_addr_t a;
        a.raw = addr;
        if (dma_sign) begin
            check_flag(mem_bvalid && mem_bready, 1'b1, "write response with uncached addr_ok");
            exp_len.push_back(burst_len_single);
            exp_strb.push_back(dma_wstrb);
        end else begin
            a.fld.word     = '0;
            a.fld.byte_sel = '0;
            exp_len.push_back(burst_len_line);
            exp_strb.push_back(4'hF);
        end
        exp_addr.push_back(a);
        exp_data.push_back(line_data);
        accepted++;
    endtask

    task automatic finish_txn();
        l2_addr_t             ea;
        logic [line_bits-1:0] ed;
        completed++;
        if (exp_addr.size() == 0) begin
            n_errors++;
            $display("Memory saw a write at %0t that no accepted request explains", $time);
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            check_addr(act_addr, ea, "start");
            check_len(act_len, exp_len.pop_front(), "burst");
            check_strb(act_strb, exp_strb.pop_front(), "burst");
            for (int i = 0; i <= int'(act_len) && i < line_words; i++) begin
                check_word(act_data[i*word_bits +: word_bits], ed[i*word_bits +: word_bits],
                           "beat");
            end
        end
    endtask

    // Memory responder. Looks at the port at the falling edge, drives at the rising edge.
    initial begin
        mem_waddr_ok = 1'b0;
        mem_wready   = 1'b0;
        mem_bvalid   = 1'b0;
        forever begin
            @(negedge clk);
            nxt_aok = 1'b0;
            nxt_wr  = 1'b0;
            nxt_bv  = 1'b0;
            if (!rstn) begin
                ph = 0;
            end else begin
                if (addr_ok) record_accept();
                case (ph)
                    0: if (mem_wvalid) begin
                        if (mem_waddr_ok) begin
                            act_addr.raw = mem_waddr;
                            act_len      = mem_len;
                            act_strb     = mem_wstrb;
                            act_data     = '0;
                            beat_idx     = 0;
                            ph           = 1;
                            nxt_wr       = roll(wr_stall);
                        end else begin
                            nxt_aok = roll(aok_stall);
                        end
                    end
                    1: begin
                        if (mem_wvalid && mem_wready) begin
                            beat_exp = act_addr;
                            if (act_len == burst_len_line) begin
                                beat_exp.fld.word = offset_width'(beat_idx);
                            end
                            check_addr(mem_waddr, beat_exp, "beat");
                            act_data[beat_idx*word_bits +: word_bits] = mem_wdata;
                            if (mem_wlast) begin
                                check_count(beat_idx, int'(act_len), "beats before wlast");
                                ph = 2;
                            end else if (beat_idx == line_words - 1) begin
                                n_errors++;
                                $display("Burst at %0t ran past four beats without wlast",
                                         $time);
                                ph = 2;
                            end else begin
                                beat_idx++;
                            end
                        end
                        if (ph == 1) nxt_wr = roll(wr_stall);
                    end
                    default: if (mem_bready) begin
                        if (mem_bvalid) begin
                            finish_txn();
                            ph = 0;
                        end else begin
                            nxt_bv = roll(b_stall);
                        end
                    end
                endcase
                if (accepted - completed > depth) begin
                    n_errors++;
                    $display("More than %0d writes accepted ahead of memory at %0t", depth, $time);
                end
            end
            @(posedge clk);
            mem_waddr_ok <= nxt_aok;
            mem_wready   <= nxt_wr;
            mem_bvalid   <= nxt_bv;
        end
    end

    task automatic send_request(int dma_pct);
        logic [line_bits-1:0] d;
        logic [31:0]          a;
        logic                 is_dma;
        for (int i = 0; i < line_words; i++) d[i*word_bits +: word_bits] = next_rand();
        a      = next_rand() << 2;
        is_dma = (next_rand() % 100) < dma_pct;
        if (next_rand() % 2) a[3:0] = 4'h0;         // Line-aligned half the time.
        @(posedge clk);
        req       <= 1'b1;
        addr      <= a;
        line_data <= d;
        dma_sign  <= is_dma;
        dma_wstrb <= 4'(next_rand());
        do @(negedge clk); while (!addr_ok);
        if (next_rand() % 4 == 0) begin
            @(posedge clk);
            req <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        req <= 1'b0;
        while (accepted != completed && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (accepted != completed) begin
            n_errors++;
            $display("Memory port did not finish the outstanding writes");
        end
    endtask

    task automatic run_test(string name, int n, int dma_pct, int stall);
        int errs_before;
        errs_before = n_errors;
        aok_stall   = stall;
        wr_stall    = stall / 2;
        b_stall     = stall / 2;
        for (int i = 0; i < n; i++) send_request(dma_pct);
        wait_drain();
        n_tests++;
        $display("test %-14s %s", name, (n_errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        req       = 1'b0;
        addr      = '0;
        line_data = '0;
        dma_sign  = 1'b0;
        dma_wstrb = '0;
        wait (rstn);
        repeat (3) begin
            @(negedge clk);
            check_flag(mem_wvalid, 1'b0, "mem_wvalid after reset");
            check_flag(mem_wlast, 1'b0, "mem_wlast after reset");
            check_flag(mem_bready, 1'b0, "mem_bready after reset");
            check_flag(addr_ok, 1'b0, "addr_ok after reset");
        end
        n_tests++;
        $display("test %-14s %s", "reset", (n_errors == 0) ? "ok" : "FAILED");
        run_test("cached_line", 8, 0, 30);
        run_test("uncached", 8, 100, 30);
        run_test("ordering", 20, 50, 20);
        run_test("backpressure", 12, 0, 90);
        run_test("mixed", 200, 25, 40);
        check_count(completed, accepted, "memory transaction");
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (total_reqs * 200) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule
